// File: include/ps2Mouse_consts.svh
`ifndef PS2MOUSE_CONSTS_SVH
`define PS2MOUSE_CONSTS_SVH

// Line filter depth in system clocks
`define PS2_FILTER_LEN      4

// Host clock inhibit before a send, 100 us at 25 MHz
`define PS2_INHIBIT_CYCLES  2500

// Host to mouse commands
`define PS2_CMD_ENABLE      8'hF4
`define PS2_CMD_SETRATE     8'hF3

// Sample rates of the IntelliMouse unlock sequence
`define PS2_RATE_A          8'hC8
`define PS2_RATE_B          8'h64
`define PS2_RATE_C          8'h50

// Mouse responses
`define PS2_RSP_ACK         8'hFA

`endif

// File: rtl/ps2MousePkg.sv
package ps2MousePkg;

    // Reader operating mode
    typedef enum logic [1:0]
    {
        MODE_OFF = 2'd0,                // Reader held idle
        MODE_STD = 2'd1,                // 3-byte packets
        MODE_EXT = 2'd2                 // 4-byte IntelliMouse packets
    } mouseModeT;

    // First packet byte
    typedef struct packed
    {
        logic yOverflow;
        logic xOverflow;
        logic ySign;
        logic xSign;
        logic alwaysOne;
        logic middle;
        logic right;
        logic left;
    } mouseStatusT;

    // Decoded view of a whole packet, byte 0 at the bottom
    typedef struct packed
    {
        logic [7:0]  dz;                // Wheel, zero in standard mode
        logic [7:0]  dy;
        logic [7:0]  dx;
        mouseStatusT status;
    } mouseFieldsT;

    // Same word, seen as bytes by the reader and as fields by the top
    typedef union packed
    {
        logic [3:0][7:0] bytes;
        mouseFieldsT     fields;
    } mousePacketT;

endpackage

// File: rtl/ps2LineIf.sv
`timescale 1ns/1ps

interface ps2LineIf;

    logic clkFall;                      // Filtered clock went low
    logic clkRise;                      // Filtered clock went high
    logic dat;                          // Filtered data level
    logic busIdle;                      // Both lines released

    modport source
    (
        output clkFall, clkRise, dat, busIdle
    );

    modport sink
    (
        input clkFall, clkRise, dat, busIdle
    );

endinterface

// File: rtl/ps2CmdIf.sv
`timescale 1ns/1ps

interface ps2CmdIf;

    logic       send;                   // One-cycle request
    logic [7:0] cmdByte;                // Valid with send
    logic       done;                   // One-cycle completion
    logic       ackOk;                  // Valid with done

    modport master
    (
        output send, cmdByte,
        input  done, ackOk
    );

    modport slave
    (
        input  send, cmdByte,
        output done, ackOk
    );

endinterface

// File: rtl/ps2LineSync.sv
`timescale 1ns/1ps
`include "ps2Mouse_consts.svh"

module ps2LineSync
(
    input  logic    CLOCK,
    input  logic    RST_n,
    input  logic    ps2ClkIn,
    input  logic    ps2DatIn,
    ps2LineIf.source line
);

    localparam int CLK   = 0;
    localparam int DAT   = 1;
    localparam int CNT_W = $clog2(`PS2_FILTER_LEN);

    logic [1:0]       meta;
    logic [1:0]       syncd;
    logic [1:0]       level;            // Accepted line levels
    logic [CNT_W-1:0] cnt [2];
    logic             fallStb;
    logic             riseStb;

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            meta    <= 2'b11;           // Released bus reads high
            syncd   <= 2'b11;
            level   <= 2'b11;
            cnt     <= '{default: '0};
            fallStb <= 1'b0;
            riseStb <= 1'b0;
        end
        else
        begin
            meta    <= {ps2DatIn, ps2ClkIn};
            syncd   <= meta;
            fallStb <= 1'b0;
            riseStb <= 1'b0;
            for (int i = 0; i < 2; i++)
            begin
                if (syncd[i] == level[i])
                    cnt[i] <= '0;       // Glitch or steady line
                else if (cnt[i] == CNT_W'(`PS2_FILTER_LEN - 1))
                begin
                    level[i] <= syncd[i];
                    cnt[i]   <= '0;
                end
                else
                    cnt[i] <= cnt[i] + 1'b1;
            end
            if (syncd[CLK] != level[CLK] && cnt[CLK] == CNT_W'(`PS2_FILTER_LEN - 1))
            begin
                fallStb <= level[CLK];  // Strobe with the new level
                riseStb <= !level[CLK];
            end
        end
    end

    assign line.clkFall = fallStb;
    assign line.clkRise = riseStb;
    assign line.dat     = level[DAT];
    assign line.busIdle = &level;

endmodule

// File: rtl/ps2ReadFrame.sv
`timescale 1ns/1ps

module ps2ReadFrame
(
    input  logic                     CLOCK,
    input  logic                     RST_n,
    ps2LineIf.sink                   line,
    input  ps2MousePkg::mouseModeT   mode,
    output ps2MousePkg::mousePacketT packet,
    output logic                     packetValid
);

    logic [3:0]               bitCnt;       // 0 start, 1..8 data, 9 parity, 10 stop
    logic [8:0]               shiftReg;     // Data LSB first, then parity
    logic                     startBad;
    logic [1:0]               byteIdx;
    logic [1:0]               lastIdx;
    logic                     lastStored;
    logic                     frameOk;
    ps2MousePkg::mousePacketT asmPacket;    // Packet under assembly

    assign lastIdx = (mode == ps2MousePkg::MODE_EXT) ? 2'd3 : 2'd2;

    // Odd parity over data plus parity bit, stop bit on the line now
    assign frameOk = !startBad && line.dat && (^shiftReg);

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            bitCnt      <= '0;
            byteIdx     <= '0;
            startBad    <= 1'b0;
            lastStored  <= 1'b0;
            packetValid <= 1'b0;
        end
        else
        begin
            packetValid <= lastStored;
            lastStored  <= 1'b0;
            if (mode == ps2MousePkg::MODE_OFF)
            begin
                bitCnt  <= '0;
                byteIdx <= '0;
            end
            else if (line.clkFall)
            begin
                if (bitCnt == 4'd10)
                begin
                    bitCnt <= '0;
                    if (!frameOk)
                        byteIdx <= '0;          // Drop the whole packet
                    else if (byteIdx == lastIdx)
                    begin
                        byteIdx    <= '0;
                        lastStored <= 1'b1;
                    end
                    else
                        byteIdx <= byteIdx + 1'b1;
                end
                else
                begin
                    if (bitCnt == 4'd0)
                        startBad <= line.dat;   // Start bit must be low
                    bitCnt <= bitCnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (line.clkFall && bitCnt >= 4'd1 && bitCnt <= 4'd9)
            shiftReg <= {line.dat, shiftReg[8:1]};
        if (line.clkFall && bitCnt == 4'd10 && frameOk)
            asmPacket.bytes[byteIdx] <= shiftReg[7:0];
        if (lastStored)
        begin
            packet <= asmPacket;
            if (mode != ps2MousePkg::MODE_EXT)
                packet.fields.dz <= '0;         // No wheel byte
        end
    end

endmodule

// File: rtl/ps2WriteFrame.sv
`timescale 1ns/1ps
`include "ps2Mouse_consts.svh"

module ps2WriteFrame
(
    input  logic     CLOCK,
    input  logic     RST_n,
    ps2LineIf.sink   line,
    ps2CmdIf.slave   cmd,
    output logic     ps2ClkDrive,
    output logic     ps2DatDrive
);

    localparam int INH_W = $clog2(`PS2_INHIBIT_CYCLES);

    typedef enum logic [2:0]
    {
        W_IDLE,
        W_INHIBIT,                      // Clock held low
        W_RELEASE,                      // Start bit out, clock let go
        W_SEND,
        W_ACK,
        W_WAIT_IDLE,
        W_RESP                          // Mouse response byte
    } wrStateT;

    wrStateT          state;
    logic [INH_W-1:0] inhCnt;
    logic [3:0]       bitCnt;
    logic [8:0]       txShift;          // Data LSB first, then parity
    logic [7:0]       rxShift;
    logic             ackLow;

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state       <= W_IDLE;
            inhCnt      <= '0;
            bitCnt      <= '0;
            ackLow      <= 1'b0;
            ps2ClkDrive <= 1'b0;
            ps2DatDrive <= 1'b0;
            cmd.done    <= 1'b0;
            cmd.ackOk   <= 1'b0;
        end
        else
        begin
            cmd.done <= 1'b0;
            case (state)
                W_IDLE:
                    if (cmd.send)
                    begin
                        ps2ClkDrive <= 1'b1;
                        inhCnt      <= '0;
                        state       <= W_INHIBIT;
                    end
                W_INHIBIT:
                    if (inhCnt == INH_W'(`PS2_INHIBIT_CYCLES - 1))
                    begin
                        ps2DatDrive <= 1'b1;    // Start bit
                        state       <= W_RELEASE;
                    end
                    else
                        inhCnt <= inhCnt + 1'b1;
                W_RELEASE:
                begin
                    ps2ClkDrive <= 1'b0;
                    if (line.clkRise)           // Mouse may clock from here on
                    begin
                        bitCnt <= '0;
                        state  <= W_SEND;
                    end
                end
                W_SEND:
                    if (line.clkFall)
                    begin
                        if (bitCnt == 4'd9)
                        begin
                            ps2DatDrive <= 1'b0;    // Stop bit by release
                            state       <= W_ACK;
                        end
                        else
                        begin
                            ps2DatDrive <= !txShift[0];
                            bitCnt      <= bitCnt + 1'b1;
                        end
                    end
                W_ACK:
                    if (line.clkFall)
                    begin
                        ackLow <= !line.dat;
                        state  <= W_WAIT_IDLE;
                    end
                W_WAIT_IDLE:
                    if (line.busIdle)
                    begin
                        bitCnt <= '0;
                        state  <= W_RESP;
                    end
                W_RESP:
                    if (line.clkFall)
                    begin
                        if (bitCnt == 4'd10)
                        begin
                            cmd.done  <= 1'b1;
                            cmd.ackOk <= ackLow && (rxShift == `PS2_RSP_ACK);
                            state     <= W_IDLE;
                        end
                        else
                            bitCnt <= bitCnt + 1'b1;
                    end
                default:
                    state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (state == W_IDLE && cmd.send)
            txShift <= {~^cmd.cmdByte, cmd.cmdByte};    // Odd parity on top
        else if (state == W_SEND && line.clkFall)
            txShift <= {1'b0, txShift[8:1]};
        if (state == W_RESP && line.clkFall && bitCnt >= 4'd1 && bitCnt <= 4'd8)
            rxShift <= {line.dat, rxShift[7:1]};
    end

endmodule

// File: rtl/ps2MouseCtrl.sv
`timescale 1ns/1ps
`include "ps2Mouse_consts.svh"

module ps2MouseCtrl
(
    input  logic                   CLOCK,
    input  logic                   RST_n,
    input  logic                   extendedMode,
    ps2CmdIf.master                cmd,
    output ps2MousePkg::mouseModeT mode,
    output logic                   initDone,
    output logic                   initFail
);

    typedef enum logic [1:0] {C_START, C_WAIT, C_DONE, C_FAIL} ctrlStateT;

    ctrlStateT  state;
    logic [2:0] step;
    logic       extLatch;               // Mode chosen at start
    logic [2:0] lastStep;

    // Magic sample-rate sequence, then enable
    function automatic logic [7:0] cmdAt(input logic [2:0] idx, input logic ext);
        if (!ext)
            return `PS2_CMD_ENABLE;
        case (idx)
            3'd0, 3'd2, 3'd4: return `PS2_CMD_SETRATE;
            3'd1:             return `PS2_RATE_A;
            3'd3:             return `PS2_RATE_B;
            3'd5:             return `PS2_RATE_C;
            default:          return `PS2_CMD_ENABLE;
        endcase
    endfunction

    assign lastStep = extLatch ? 3'd6 : 3'd0;

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state       <= C_START;
            step        <= '0;
            extLatch    <= 1'b0;
            cmd.send    <= 1'b0;
            cmd.cmdByte <= '0;
            mode        <= ps2MousePkg::MODE_OFF;
            initDone    <= 1'b0;
            initFail    <= 1'b0;
        end
        else
        begin
            cmd.send <= 1'b0;
            case (state)
                C_START:
                begin
                    extLatch    <= extendedMode;
                    step        <= '0;
                    cmd.send    <= 1'b1;
                    cmd.cmdByte <= cmdAt(3'd0, extendedMode);
                    state       <= C_WAIT;
                end
                C_WAIT:
                    if (cmd.done)
                    begin
                        if (!cmd.ackOk)
                        begin
                            initFail <= 1'b1;   // Stop here for good
                            state    <= C_FAIL;
                        end
                        else if (step == lastStep)
                        begin
                            initDone <= 1'b1;
                            mode     <= extLatch ? ps2MousePkg::MODE_EXT
                                                 : ps2MousePkg::MODE_STD;
                            state    <= C_DONE;
                        end
                        else
                        begin
                            step        <= step + 1'b1;
                            cmd.send    <= 1'b1;
                            cmd.cmdByte <= cmdAt(step + 1'b1, extLatch);
                        end
                    end
                default:
                    state <= state;             // Done or failed, hold
            endcase
        end
    end

endmodule

// File: rtl/ps2MouseTop.sv
`timescale 1ns/1ps

module ps2MouseTop
(
    input  logic       CLOCK,
    input  logic       RST_n,
    input  logic       ps2ClkIn,
    input  logic       ps2DatIn,
    output logic       ps2ClkDrive,     // Pull clock low
    output logic       ps2DatDrive,     // Pull data low
    input  logic       extendedMode,
    output logic       initDone,
    output logic       initFail,
    output logic       packetValid,
    output logic [2:0] buttons,
    output logic [8:0] dx,
    output logic [8:0] dy,
    output logic [7:0] dz
);

    ps2MousePkg::mouseModeT   mode;
    ps2MousePkg::mousePacketT packet;

    ps2LineIf lineBus();
    ps2CmdIf  cmdBus();

    ps2LineSync lineSync_i
    (
        .CLOCK    (CLOCK),
        .RST_n    (RST_n),
        .ps2ClkIn (ps2ClkIn),
        .ps2DatIn (ps2DatIn),
        .line     (lineBus.source)
    );

    ps2ReadFrame readFrame_i
    (
        .CLOCK       (CLOCK),
        .RST_n       (RST_n),
        .line        (lineBus.sink),
        .mode        (mode),
        .packet      (packet),
        .packetValid (packetValid)
    );

    ps2WriteFrame writeFrame_i
    (
        .CLOCK       (CLOCK),
        .RST_n       (RST_n),
        .line        (lineBus.sink),
        .cmd         (cmdBus.slave),
        .ps2ClkDrive (ps2ClkDrive),
        .ps2DatDrive (ps2DatDrive)
    );

    ps2MouseCtrl mouseCtrl_i
    (
        .CLOCK        (CLOCK),
        .RST_n        (RST_n),
        .extendedMode (extendedMode),
        .cmd          (cmdBus.master),
        .mode         (mode),
        .initDone     (initDone),
        .initFail     (initFail)
    );

    // Packet register holds between packets, so these hold too
    assign buttons = {packet.fields.status.middle,
                      packet.fields.status.right,
                      packet.fields.status.left};
    assign dx      = {packet.fields.status.xSign, packet.fields.dx};
    assign dy      = {packet.fields.status.ySign, packet.fields.dy};
    assign dz      = packet.fields.dz;

endmodule

// File: verification/ps2MouseModel.sv
`timescale 1ns/1ps

module ps2MouseModel
(
    input  logic CLOCK,
    input  logic clkLine,                   // Wired bus levels
    input  logic datLine,
    output logic clkOut,                    // Low pulls the line down
    output logic datOut
);

    localparam int HALF = 12;               // Device clock half period in system clocks

    logic [8:0] txQueue [$];                // Bit 8 flips the parity bit
    logic [9:0] rxLog [$];                  // Stop, parity, data
    logic [8:0] entry;
    logic       nack;
    logic       active;

    task automatic idle(input int n);
        repeat (n) @(negedge CLOCK);
    endtask

    // Device to host frame, data changes while the clock is high
    task automatic sendFrame(input logic [7:0] data, input logic badParity);
        logic [10:0] frame;
        frame = {1'b1, (~^data) ^ badParity, data, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            datOut = frame[i];
            idle(HALF / 2);
            clkOut = 1'b0;
            idle(HALF);
            clkOut = 1'b1;
            idle(HALF / 2);
        end
        datOut = 1'b1;
        idle(2 * HALF);                     // Gap between frames
    endtask

    // Host to device frame, bit read at the end of each low phase
    task automatic receiveCommand();
        logic [9:0] bits;
        idle(2 * HALF);
        for (int i = 0; i < 10; i++)
        begin
            clkOut = 1'b0;
            idle(HALF);
            bits[i] = datLine;
            clkOut = 1'b1;
            idle(HALF);
        end
        datOut = 1'b0;                      // Line ACK
        idle(HALF / 2);
        clkOut = 1'b0;
        idle(HALF);
        clkOut = 1'b1;
        idle(HALF / 2);
        datOut = 1'b1;
        rxLog.push_back(bits);
        idle(3 * HALF);
        sendFrame(nack ? 8'hFE : 8'hFA, 1'b0);
    endtask

    task automatic queueByte(input logic [7:0] data, input logic badParity);
        txQueue.push_back({badParity, data});
    endtask

    task automatic setNack(input logic value);
        nack = value;
    endtask

    task automatic clearLog();
        rxLog.delete();
    endtask

    function automatic int logSize();
        return rxLog.size();
    endfunction

    function automatic logic [9:0] logAt(input int idx);
        return rxLog[idx];
    endfunction

    function automatic logic busy();
        return active || (txQueue.size() > 0);
    endfunction

    initial
    begin
        clkOut = 1'b1;
        datOut = 1'b1;
        nack   = 1'b0;
        active = 1'b0;
        forever
        begin
            @(negedge CLOCK);
            if (!clkLine)                   // Host inhibits the clock
            begin
                active = 1'b1;
                while (!clkLine)
                    @(negedge CLOCK);
                if (!datLine)               // Request to send
                    receiveCommand();
                active = 1'b0;
            end
            else if (txQueue.size() > 0)
            begin
                active = 1'b1;
                entry  = txQueue.pop_front();
                sendFrame(entry[7:0], entry[8]);
                active = 1'b0;
            end
        end
    end

endmodule

// File: verification/ps2MouseTb.sv
`timescale 1ns/1ps

module ps2MouseTb;

    localparam int CLK_PERIOD   = 40;
    localparam int BIT_CYCLES   = 24;       // Device clock period in system clocks
    localparam int INHIBIT      = 2500;
    localparam int NUM_PACKETS  = 8;
    localparam int NUM_COMMANDS = 9;        // 1 standard, 7 extended, 1 rejected
    localparam int NUM_BYTES    = NUM_PACKETS * 7 + 9;
    localparam int FRAME_CYCLES = 13 * BIT_CYCLES;
    localparam int CMD_CYCLES   = INHIBIT + 2 * FRAME_CYCLES + 4 * BIT_CYCLES;
    localparam int LIMIT_CYCLES = 2 * (NUM_COMMANDS * CMD_CYCLES + NUM_BYTES * FRAME_CYCLES)
                                  + 5000;

    logic       CLOCK;
    logic       RST_n;
    logic       extendedMode;
    logic       ps2ClkIn;
    logic       ps2DatIn;
    logic       ps2ClkDrive;
    logic       ps2DatDrive;
    logic       initDone;
    logic       initFail;
    logic       packetValid;
    logic [2:0] buttons;
    logic [8:0] dx;
    logic [8:0] dy;
    logic [7:0] dz;
    logic       modelClk;
    logic       modelDat;

    logic [31:0] expQueue [$];
    logic [31:0] gotQueue [$];
    logic [7:0]  expCmds [$];

    // Open-collector bus
    assign ps2ClkIn = modelClk & ~ps2ClkDrive;
    assign ps2DatIn = modelDat & ~ps2DatDrive;

    ps2MouseTop ps2MouseTop_i
    (
        .CLOCK        (CLOCK),
        .RST_n        (RST_n),
        .ps2ClkIn     (ps2ClkIn),
        .ps2DatIn     (ps2DatIn),
        .ps2ClkDrive  (ps2ClkDrive),
        .ps2DatDrive  (ps2DatDrive),
        .extendedMode (extendedMode),
        .initDone     (initDone),
        .initFail     (initFail),
        .packetValid  (packetValid),
        .buttons      (buttons),
        .dx           (dx),
        .dy           (dy),
        .dz           (dz)
    );

    ps2MouseModel mouseModel_i
    (
        .CLOCK   (CLOCK),
        .clkLine (ps2ClkIn),
        .datLine (ps2DatIn),
        .clkOut  (modelClk),
        .datOut  (modelDat)
    );

    always #(CLK_PERIOD / 2) CLOCK = ~CLOCK;

    always @(negedge CLOCK)
    begin
        if (RST_n && packetValid)
            gotQueue.push_back({3'b000, buttons, dx, dy, dz});
    end

    initial
    begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("ERROR: simulation timed out after %0d clock cycles", LIMIT_CYCLES);
        $display("Checks failed");
        $fatal(1);
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Buttons, signed 9-bit moves and wheel from the raw packet bytes
    function automatic logic [31:0] expectFields(input logic [7:0] b0, input logic [7:0] b1,
                                                 input logic [7:0] b2, input logic [7:0] b3,
                                                 input logic ext);
        logic [2:0] btn;
        logic [8:0] ex;
        logic [8:0] ey;
        logic [7:0] ez;
        btn = b0[2:0];                      // Middle, right, left
        ex  = {b0[4], b1};
        ey  = {b0[5], b2};
        ez  = ext ? b3 : 8'h00;
        return {3'b000, btn, ex, ey, ez};
    endfunction

    task automatic applyReset(input logic ext, input logic nack);
        @(negedge CLOCK);
        RST_n        = 1'b0;
        extendedMode = ext;
        mouseModel_i.setNack(nack);
        mouseModel_i.clearLog();
        expQueue.delete();
        gotQueue.delete();
        repeat (10) @(negedge CLOCK);
        RST_n = 1'b1;
    endtask

    task automatic waitInit();
        while (!initDone && !initFail)
            @(negedge CLOCK);
    endtask

    task automatic waitIdle();
        while (mouseModel_i.busy())
            @(negedge CLOCK);
        repeat (BIT_CYCLES) @(negedge CLOCK);
    endtask

    // Logged entry holds stop, odd parity and data
    task automatic checkCommands(input string name);
        checkValue({name, " count"}, expCmds.size(), mouseModel_i.logSize());
        foreach (expCmds[i])
            checkValue($sformatf("%s byte %0d", name, i),
                       {22'd0, 1'b1, ($countones(expCmds[i]) % 2 == 0), expCmds[i]},
                       32'(mouseModel_i.logAt(i)));
    endtask

    // A bad packet gets its last byte corrupted so the next one stays aligned
    task automatic sendPacket(input logic ext, input logic badParity);
        logic [7:0] b [4];
        int         last;
        last = ext ? 3 : 2;
        b[0] = 8'($urandom) | 8'h08;        // Always-one bit
        for (int i = 1; i < 4; i++)
            b[i] = 8'($urandom);
        for (int i = 0; i <= last; i++)
            mouseModel_i.queueByte(b[i], badParity && (i == last));
        if (!badParity)
            expQueue.push_back(expectFields(b[0], b[1], b[2], b[3], ext));
    endtask

    task automatic comparePackets(input string name);
        waitIdle();
        checkValue({name, " count"}, expQueue.size(), gotQueue.size());
        foreach (expQueue[i])
            checkValue($sformatf("%s packet %0d", name, i), expQueue[i], gotQueue[i]);
        expQueue.delete();
        gotQueue.delete();
    endtask

    initial
    begin
        CLOCK        = 1'b0;
        RST_n        = 1'b0;
        extendedMode = 1'b0;
        void'($urandom(99306));

        applyReset(1'b0, 1'b0);
        waitInit();
        checkValue("std init done", 32'd1, 32'(initDone));
        checkValue("std init fail", 32'd0, 32'(initFail));
        expCmds = '{8'hF4};
        checkCommands("std init");
        for (int i = 0; i < NUM_PACKETS; i++)
            sendPacket(1'b0, 1'b0);
        comparePackets("std packets");
        sendPacket(1'b0, 1'b1);             // Dropped by the reader
        sendPacket(1'b0, 1'b0);
        comparePackets("frame error");

        applyReset(1'b1, 1'b0);
        waitInit();
        checkValue("ext init done", 32'd1, 32'(initDone));
        checkValue("ext init fail", 32'd0, 32'(initFail));
        expCmds = '{8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50, 8'hF4};
        checkCommands("ext init");
        for (int i = 0; i < NUM_PACKETS; i++)
            sendPacket(1'b1, 1'b0);
        comparePackets("ext packets");

        applyReset(1'b0, 1'b1);
        waitInit();
        checkValue("nack init fail", 32'd1, 32'(initFail));
        checkValue("nack init done", 32'd0, 32'(initDone));
        expCmds = '{8'hF4};
        checkCommands("nack init");
        sendPacket(1'b0, 1'b0);             // Good packet while the reader is off
        waitIdle();
        checkValue("nack packets", 32'd0, gotQueue.size());
        checkValue("nack still done", 32'd0, 32'(initDone));

        $display("All checks passed");
        $finish;
    end

endmodule

// File: ps2MouseTop.f
+incdir+include
rtl/ps2MousePkg.sv
rtl/ps2LineIf.sv
rtl/ps2CmdIf.sv
rtl/ps2LineSync.sv
rtl/ps2ReadFrame.sv
rtl/ps2WriteFrame.sv
rtl/ps2MouseCtrl.sv
rtl/ps2MouseTop.sv
verification/ps2MouseModel.sv
verification/ps2MouseTb.sv

// File: Makefile
SIM       = verilator
TOP       = ps2MouseTb
FILELIST  = ps2MouseTop.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --timescale 1ns/1ps --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
